/* logic/mem_bus_pkg.sv */
// GPU memory channel widths, local memory address map and line types; import into bridge RTL
`default_nettype none

package mem_bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // channel widths
    //////////////////////////////////////////////////////////////////////

    // byte offset inside one 64-byte cache line
    localparam int LINE_OFFSET_BITS = 6;
    // line address, byte address minus line offset
    localparam int MEM_ADDR_W       = 26;
    localparam int BYTE_ADDR_W      = MEM_ADDR_W + LINE_OFFSET_BITS;
    localparam int MEM_DATA_W       = 512;
    // one enable per data byte
    localparam int MEM_BYTEEN_W     = 64;
    localparam int MEM_TAG_W        = 56;

    //////////////////////////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////////////////////////

    // local memory byte base
    localparam logic [BYTE_ADDR_W-1:0] LOCAL_BASE_ADDR = 32'hF000_0000;
    // local region spans 2**14 bytes
    localparam int LOCAL_SPACE_BITS = 14;
    // top bits shared by local region and the reserved gap
    localparam int GAP_MATCH_BITS   = 17;

    //////////////////////////////////////////////////////////////////////
    // line channel types
    //////////////////////////////////////////////////////////////////////

    typedef logic [MEM_ADDR_W-1:0]   mem_addr_t;
    typedef logic [MEM_DATA_W-1:0]   mem_data_t;
    typedef logic [MEM_BYTEEN_W-1:0] mem_byteen_t;
    typedef logic [MEM_TAG_W-1:0]    mem_tag_t;

endpackage

`default_nettype wire

/* logic/run_ctrl_pkg.sv */
// register map, data word types and run state encoding of the GPU control block; import where needed
`default_nettype none

package run_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // register slave widths
    //////////////////////////////////////////////////////////////////////

    localparam int REG_DATA_W   = 32;
    // one strobe per byte of a data word
    localparam int REG_STROBE_W = 4;
    localparam int REG_ADDR_W   = 32;

    typedef logic [REG_DATA_W-1:0]   reg_data_t;
    typedef logic [REG_STROBE_W-1:0] reg_strobe_t;
    typedef logic [REG_ADDR_W-1:0]   reg_addr_t;

    //////////////////////////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////////////////////////

    // status, bit 0 set while the GPU runs
    localparam reg_addr_t STATUS_REG_ADDR = 32'hF000_8000;
    // start, write 1 to bit 0 to release reset
    localparam reg_addr_t START_REG_ADDR  = 32'hF000_8004;
    // GPU start address
    localparam reg_addr_t PC_REG_ADDR     = 32'hF000_8008;

    // only word offsets inside the block are decoded
    localparam int REG_DECODE_HI = 14;
    localparam int REG_DECODE_LO = 2;

    // start address out of reset, base of local memory
    localparam reg_data_t PC_RESET_DEFAULT = 32'hF000_0000;

    // halt holds GPU in reset
    typedef enum logic
    {
        RUN_HALT   = 1'b0,
        RUN_ACTIVE = 1'b1
    } run_state_t;

endpackage

`default_nettype wire

/* logic/mem_req_router.sv */
// address decode for GPU line requests, steering valid to local memory or the bus manager
`timescale 1ns/1ps
`default_nettype none

module mem_req_router
    import mem_bus_pkg::*;
(
    // from GPU
    input  logic      req_valid,
    input  mem_addr_t req_addr,
    // back-end readies
    input  logic      local_req_ready,
    input  logic      bus_req_ready,
    // steered valids
    output logic      local_req_valid,
    output logic      bus_req_valid,
    // back to GPU
    output logic      req_ready
);

    //////////////////////////////////////////////////////////////////////
    // region decode
    //////////////////////////////////////////////////////////////////////

    logic in_local;
    logic in_gap_window;

    // line address bits above the local region vs byte base bits
    assign in_local =
        (req_addr[MEM_ADDR_W-1:LOCAL_SPACE_BITS-LINE_OFFSET_BITS] ==
         LOCAL_BASE_ADDR[BYTE_ADDR_W-1:LOCAL_SPACE_BITS]);

    // top bits equal to base, local region or the reserved gap
    assign in_gap_window =
        (req_addr[MEM_ADDR_W-1:MEM_ADDR_W-GAP_MATCH_BITS] ==
         LOCAL_BASE_ADDR[BYTE_ADDR_W-1:BYTE_ADDR_W-GAP_MATCH_BITS]);

    //////////////////////////////////////////////////////////////////////
    // valid steering
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        local_req_valid = 1'b0;
        bus_req_valid   = 1'b0;
        if (req_valid)
        begin
            if (in_local)
            begin
                local_req_valid = 1'b1;
            end
            else if (!in_gap_window)
            begin
                bus_req_valid = 1'b1;
            end
            // gap hit drops the request
        end
    end

    // GPU waits until both sides can take a request
    assign req_ready = local_req_ready & bus_req_ready;

endmodule

`default_nettype wire

/* logic/mem_rsp_merger.sv */
// merges local memory and bus manager responses into one GPU stream, buffering a collision
`timescale 1ns/1ps
`default_nettype none

module mem_rsp_merger
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      nRST,
    // local memory side
    input  logic      local_rsp_valid,
    input  mem_data_t local_rsp_data,
    input  mem_tag_t  local_rsp_tag,
    // bus manager side
    input  logic      bus_rsp_valid,
    input  mem_data_t bus_rsp_data,
    input  mem_tag_t  bus_rsp_tag,
    // merged stream to GPU
    output logic      rsp_valid,
    output mem_data_t rsp_data,
    output mem_tag_t  rsp_tag
);

    //////////////////////////////////////////////////////////////////////
    // collision buffer
    //////////////////////////////////////////////////////////////////////

    logic      collide;
    logic      buf_valid;
    mem_data_t buf_data;
    mem_tag_t  buf_tag;

    // both back ends answering in one cycle
    assign collide = local_rsp_valid & bus_rsp_valid;

    // one-cycle flag, cleared whenever no collision
    always_ff @(posedge clk, negedge nRST)
    begin
        if (!nRST)
        begin
            buf_valid <= 1'b0;
        end
        else
        begin
            buf_valid <= collide;
        end
    end

    // bus payload parked on collision
    always_ff @(posedge clk)
    begin
        if (collide)
        begin
            buf_data <= bus_rsp_data;
            buf_tag  <= bus_rsp_tag;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output select
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // local first, then bus, then parked entry
        if (local_rsp_valid)
        begin
            rsp_data = local_rsp_data;
            rsp_tag  = local_rsp_tag;
        end
        else if (bus_rsp_valid)
        begin
            rsp_data = bus_rsp_data;
            rsp_tag  = bus_rsp_tag;
        end
        else
        begin
            rsp_data = buf_data;
            rsp_tag  = buf_tag;
        end
    end

    // parked entry shown once, no back-pressure held
    assign rsp_valid = local_rsp_valid | bus_rsp_valid | buf_valid;

endmodule

`default_nettype wire

/* logic/run_ctrl_regs.sv */
// GPU control/status register slave with halt/run FSM holding the GPU in reset until started
`timescale 1ns/1ps
`default_nettype none

module run_ctrl_regs
    import run_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        nRST,
    // register slave
    input  logic        reg_wen,
    input  reg_addr_t   reg_addr,
    input  reg_data_t   reg_wdata,
    input  reg_strobe_t reg_strobe,
    output reg_data_t   reg_rdata,
    // GPU control
    input  logic        gpu_busy,
    output logic        gpu_reset,
    output reg_data_t   gpu_pc_reset
);

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////

    logic       sel_status;
    logic       sel_start;
    logic       sel_pc;
    logic       start_hit;
    logic       busy_q;
    logic       busy_fall;
    run_state_t state;
    run_state_t state_next;
    reg_data_t  pc_q;
    reg_data_t  pc_next;

    // word offset compare only
    assign sel_status = (reg_addr[REG_DECODE_HI:REG_DECODE_LO] ==
                         STATUS_REG_ADDR[REG_DECODE_HI:REG_DECODE_LO]);
    assign sel_start  = (reg_addr[REG_DECODE_HI:REG_DECODE_LO] ==
                         START_REG_ADDR[REG_DECODE_HI:REG_DECODE_LO]);
    assign sel_pc     = (reg_addr[REG_DECODE_HI:REG_DECODE_LO] ==
                         PC_REG_ADDR[REG_DECODE_HI:REG_DECODE_LO]);

    //////////////////////////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        reg_rdata = '0;
        if (sel_status)
        begin
            // running flag in bit 0
            reg_rdata = reg_data_t'(state == RUN_ACTIVE);
        end
        else if (sel_start)
        begin
            // write-only trigger
            reg_rdata = '0;
        end
        else if (sel_pc)
        begin
            reg_rdata = pc_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////////////

    // start needs strobe and data bit 0
    assign start_hit = reg_wen & sel_start & reg_strobe[0] & reg_wdata[0];

    // byte-merged start address
    always_comb
    begin
        pc_next = pc_q;
        if (reg_wen && sel_pc)
        begin
            for (int b = 0; b < REG_STROBE_W; b++)
            begin
                if (reg_strobe[b])
                begin
                    pc_next[b*8 +: 8] = reg_wdata[b*8 +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // halt/run FSM
    //////////////////////////////////////////////////////////////////////

    // busy dropping ends a run
    assign busy_fall = busy_q & ~gpu_busy;

    always_comb
    begin
        state_next = state;
        case (state)
            RUN_HALT:
            begin
                if (start_hit)
                begin
                    state_next = RUN_ACTIVE;
                end
            end
            RUN_ACTIVE:
            begin
                if (busy_fall)
                begin
                    state_next = RUN_HALT;
                end
            end
            default:
            begin
                state_next = RUN_HALT;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRST)
    begin
        if (!nRST)
        begin
            state  <= RUN_HALT;
            busy_q <= 1'b0;
            pc_q   <= PC_RESET_DEFAULT;
        end
        else
        begin
            state  <= state_next;
            busy_q <= gpu_busy;
            pc_q   <= pc_next;
        end
    end

    // GPU also held while the bridge itself resets
    assign gpu_reset    = ~nRST | (state == RUN_HALT);
    assign gpu_pc_reset = pc_q;

endmodule

`default_nettype wire

/* logic/gpu_bridge_top.sv */
// bridge top joining GPU memory port, local memory and bus manager channels, and run control
`timescale 1ns/1ps
`default_nettype none

module gpu_bridge_top
    import mem_bus_pkg::*, run_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        nRST,
    // GPU request
    input  logic        req_valid,
    input  logic        req_rw,
    input  mem_byteen_t req_byteen,
    input  mem_addr_t   req_addr,
    input  mem_data_t   req_data,
    input  mem_tag_t    req_tag,
    output logic        req_ready,
    // back-end request valids and readies
    output logic        local_req_valid,
    input  logic        local_req_ready,
    output logic        bus_req_valid,
    input  logic        bus_req_ready,
    // request payload, shared by both back ends
    output logic        fwd_rw,
    output mem_byteen_t fwd_byteen,
    output mem_addr_t   fwd_addr,
    output mem_data_t   fwd_data,
    output mem_tag_t    fwd_tag,
    // local memory response
    input  logic        local_rsp_valid,
    input  mem_data_t   local_rsp_data,
    input  mem_tag_t    local_rsp_tag,
    // bus manager response
    input  logic        bus_rsp_valid,
    input  mem_data_t   bus_rsp_data,
    input  mem_tag_t    bus_rsp_tag,
    // response readies
    input  logic        rsp_ready,
    output logic        local_rsp_ready,
    output logic        bus_rsp_ready,
    // merged response to GPU
    output logic        rsp_valid,
    output mem_data_t   rsp_data,
    output mem_tag_t    rsp_tag,
    // register slave
    input  logic        reg_wen,
    input  reg_addr_t   reg_addr,
    input  reg_data_t   reg_wdata,
    input  reg_strobe_t reg_strobe,
    output reg_data_t   reg_rdata,
    // GPU control
    input  logic        gpu_busy,
    output logic        gpu_reset,
    output reg_data_t   gpu_pc_reset
);

    //////////////////////////////////////////////////////////////////////
    // request path
    //////////////////////////////////////////////////////////////////////

    mem_req_router u_router (
        .req_valid       (req_valid),
        .req_addr        (req_addr),
        .local_req_ready (local_req_ready),
        .bus_req_ready   (bus_req_ready),
        .local_req_valid (local_req_valid),
        .bus_req_valid   (bus_req_valid),
        .req_ready       (req_ready)
    );

    // payload goes out untouched, only valid is steered
    assign fwd_rw     = req_rw;
    assign fwd_byteen = req_byteen;
    assign fwd_addr   = req_addr;
    assign fwd_data   = req_data;
    assign fwd_tag    = req_tag;

    //////////////////////////////////////////////////////////////////////
    // response path
    //////////////////////////////////////////////////////////////////////

    mem_rsp_merger u_merger (
        .clk             (clk),
        .nRST            (nRST),
        .local_rsp_valid (local_rsp_valid),
        .local_rsp_data  (local_rsp_data),
        .local_rsp_tag   (local_rsp_tag),
        .bus_rsp_valid   (bus_rsp_valid),
        .bus_rsp_data    (bus_rsp_data),
        .bus_rsp_tag     (bus_rsp_tag),
        .rsp_valid       (rsp_valid),
        .rsp_data        (rsp_data),
        .rsp_tag         (rsp_tag)
    );

    // GPU ready fanned out to both
    assign local_rsp_ready = rsp_ready;
    assign bus_rsp_ready   = rsp_ready;

    //////////////////////////////////////////////////////////////////////
    // run control
    //////////////////////////////////////////////////////////////////////

    run_ctrl_regs u_ctrl (
        .clk          (clk),
        .nRST         (nRST),
        .reg_wen      (reg_wen),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_strobe   (reg_strobe),
        .reg_rdata    (reg_rdata),
        .gpu_busy     (gpu_busy),
        .gpu_reset    (gpu_reset),
        .gpu_pc_reset (gpu_pc_reset)
    );

endmodule

`default_nettype wire

/* bench/gpu_bridge_check.svh */
// reference models, random source and typed compare tasks, included inside the bridge testbench
`ifndef GPU_BRIDGE_CHECK_SVH
`define GPU_BRIDGE_CHECK_SVH

//////////////////////////////////////////////////////////////////////
// random source
//////////////////////////////////////////////////////////////////////

// 32-bit LCG with its state in the testbench
function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// full line of random words
function automatic mem_data_t rand_data();
    mem_data_t d;
    for (int i = 0; i < MEM_DATA_W / 32; i++)
    begin
        d[i*32 +: 32] = next_rand();
    end
    return d;
endfunction

function automatic mem_tag_t rand_tag();
    return mem_tag_t'({next_rand(), next_rand()});
endfunction

//////////////////////////////////////////////////////////////////////
// reference models
//////////////////////////////////////////////////////////////////////

// returns {local, bus} from byte ranges of the local window and the gap
function automatic logic [1:0] expect_route(logic valid, mem_addr_t addr);
    logic [31:0] byte_addr;
    logic [1:0]  r;
    byte_addr = {addr, {LINE_OFFSET_BITS{1'b0}}};
    r = 2'b00;
    if (valid)
    begin
        if (byte_addr >= LOCAL_BASE_ADDR &&
            byte_addr < LOCAL_BASE_ADDR + (32'd1 << LOCAL_SPACE_BITS))
        begin
            r = 2'b10;
        end
        else if (!(byte_addr >= LOCAL_BASE_ADDR &&
                   byte_addr < LOCAL_BASE_ADDR + (32'd1 << (32 - GAP_MATCH_BITS))))
        begin
            r = 2'b01;
        end
    end
    return r;
endfunction

// word offset compare on bits 14..2
function automatic logic offset_match(reg_addr_t addr, reg_addr_t target);
    return addr[REG_DECODE_HI:REG_DECODE_LO] == target[REG_DECODE_HI:REG_DECODE_LO];
endfunction

function automatic reg_data_t expect_rdata(reg_addr_t addr, run_state_t st, reg_data_t pc);
    reg_data_t d;
    d = '0;
    if (offset_match(addr, STATUS_REG_ADDR))
    begin
        d[0] = (st == RUN_ACTIVE);
    end
    else if (offset_match(addr, PC_REG_ADDR))
    begin
        d = pc;
    end
    // start and unmapped offsets read zero
    return d;
endfunction

// per-byte merge under strobes
function automatic reg_data_t expect_pc_merge(reg_data_t old, reg_data_t wdata,
                                              reg_strobe_t strobe);
    reg_data_t d;
    d = old;
    for (int b = 0; b < REG_STROBE_W; b++)
    begin
        if (strobe[b])
        begin
            d[b*8 +: 8] = wdata[b*8 +: 8];
        end
    end
    return d;
endfunction

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_route(logic got, logic exp, string what);
    if (got !== exp)
    begin
        route_errs++;
        $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

// payload copied to both back ends
task automatic check_fwd(mem_byteen_t got_be, mem_addr_t got_a, mem_data_t got_d,
                         mem_tag_t got_t, mem_byteen_t exp_be, mem_addr_t exp_a,
                         mem_data_t exp_d, mem_tag_t exp_t);
    if (got_be !== exp_be || got_a !== exp_a || got_d !== exp_d || got_t !== exp_t)
    begin
        route_errs++;
        $display("Mismatch at %0t: forwarded payload differs from the request", $time);
        $display("  addr %h tag %h byteen %h", got_a, got_t, got_be);
        $display("  expected addr %h tag %h byteen %h", exp_a, exp_t, exp_be);
        $display("  data %h", got_d);
        $display("  expected data %h", exp_d);
    end
endtask

task automatic check_rsp(logic got_v, mem_data_t got_d, mem_tag_t got_t,
                         logic exp_v, mem_data_t exp_d, mem_tag_t exp_t);
    // payload only matters while valid
    if (got_v !== exp_v || (exp_v && (got_d !== exp_d || got_t !== exp_t)))
    begin
        rsp_errs++;
        $display("Mismatch at %0t: rsp valid %b tag %h, expected valid %b tag %h",
                 $time, got_v, got_t, exp_v, exp_t);
        $display("  data %h", got_d);
        $display("  expected data %h", exp_d);
    end
endtask

task automatic check_reg(reg_data_t got, reg_data_t exp, string what);
    if (got !== exp)
    begin
        reg_errs++;
        $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_reset(logic got, logic exp, string what);
    if (got !== exp)
    begin
        ctrl_errs++;
        $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

`endif

/* bench/gpu_bridge_tb.sv */
// testbench for the GPU bridge top; drives requests, responses and register traffic
`timescale 1ns/1ps
`default_nettype none

module gpu_bridge_tb
    import mem_bus_pkg::*, run_ctrl_pkg::*;
();

    //////////////////////////////////////////////////////////////////////
    // run length
    //////////////////////////////////////////////////////////////////////

    localparam int RESET_CYCLES = 4;
    // 8 boundary addresses plus 200 random
    localparam int ROUTE_CYCLES = 208;
    // 20 slots of three cycles
    localparam int RSP_CYCLES   = 60;
    localparam int REG_CYCLES   = 22;
    localparam int STIM_CYCLES  = RESET_CYCLES + ROUTE_CYCLES + RSP_CYCLES + REG_CYCLES + 3;
    localparam int CYCLE_LIMIT  = 2 * STIM_CYCLES + 100;

    //////////////////////////////////////////////////////////////////////
    // DUT signals
    //////////////////////////////////////////////////////////////////////

    logic        clk;
    logic        nRST;
    logic        req_valid;
    logic        req_rw;
    mem_byteen_t req_byteen;
    mem_addr_t   req_addr;
    mem_data_t   req_data;
    mem_tag_t    req_tag;
    logic        req_ready;
    logic        local_req_valid;
    logic        local_req_ready;
    logic        bus_req_valid;
    logic        bus_req_ready;
    logic        fwd_rw;
    mem_byteen_t fwd_byteen;
    mem_addr_t   fwd_addr;
    mem_data_t   fwd_data;
    mem_tag_t    fwd_tag;
    logic        local_rsp_valid;
    mem_data_t   local_rsp_data;
    mem_tag_t    local_rsp_tag;
    logic        bus_rsp_valid;
    mem_data_t   bus_rsp_data;
    mem_tag_t    bus_rsp_tag;
    logic        rsp_ready;
    logic        local_rsp_ready;
    logic        bus_rsp_ready;
    logic        rsp_valid;
    mem_data_t   rsp_data;
    mem_tag_t    rsp_tag;
    logic        reg_wen;
    reg_addr_t   reg_addr;
    reg_data_t   reg_wdata;
    reg_strobe_t reg_strobe;
    reg_data_t   reg_rdata;
    logic        gpu_busy;
    logic        gpu_reset;
    reg_data_t   gpu_pc_reset;

    // checker model state
    logic        pend_valid;
    mem_data_t   pend_data;
    mem_tag_t    pend_tag;
    run_state_t  model_state;
    reg_data_t   model_pc;
    logic        model_busy_q;

    logic [31:0] lcg_state;
    int          route_errs = 0;
    int          rsp_errs = 0;
    int          reg_errs = 0;
    int          ctrl_errs = 0;
    int          cycle_count = 0;

    `include "gpu_bridge_check.svh"

    gpu_bridge_top u_dut (.*);

    always
    begin
        #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks driving on the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic drive_request(mem_addr_t addr, logic valid);
        logic [31:0] r;
        @(negedge clk);
        r = next_rand();
        req_valid       = valid;
        req_addr        = addr;
        req_rw          = r[0];
        req_byteen      = {next_rand(), next_rand()};
        req_data        = rand_data();
        req_tag         = rand_tag();
        // readies mostly high
        local_req_ready = r[1] | r[2];
        bus_req_ready   = r[3] | r[4];
    endtask

    // kind is {local, bus}
    task automatic drive_response(logic [1:0] kind);
        @(negedge clk);
        local_rsp_valid = kind[1];
        bus_rsp_valid   = kind[0];
        local_rsp_data  = rand_data();
        local_rsp_tag   = rand_tag();
        bus_rsp_data    = rand_data();
        bus_rsp_tag     = rand_tag();
    endtask

    task automatic reg_cycle(logic wen, reg_addr_t addr, reg_data_t wdata,
                             reg_strobe_t strobe);
        @(negedge clk);
        reg_wen    = wen;
        reg_addr   = addr;
        reg_wdata  = wdata;
        reg_strobe = strobe;
    endtask

    task automatic set_busy(logic busy);
        @(negedge clk);
        reg_wen  = 1'b0;
        gpu_busy = busy;
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        mem_addr_t   edge_addr [8];
        logic [31:0] r;
        clk             = 1'b0;
        nRST            = 1'b0;
        lcg_state       = 32'h3bd57184;
        req_valid       = 1'b0;
        req_rw          = 1'b0;
        req_byteen      = '0;
        req_addr        = '0;
        req_data        = '0;
        req_tag         = '0;
        local_req_ready = 1'b1;
        bus_req_ready   = 1'b1;
        local_rsp_valid = 1'b0;
        local_rsp_data  = '0;
        local_rsp_tag   = '0;
        bus_rsp_valid   = 1'b0;
        bus_rsp_data    = '0;
        bus_rsp_tag     = '0;
        rsp_ready       = 1'b1;
        reg_wen         = 1'b0;
        reg_addr        = '0;
        reg_wdata       = '0;
        reg_strobe      = '0;
        gpu_busy        = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        nRST = 1'b1;

        // below base, local ends, gap ends, above gap, address extremes
        edge_addr = '{26'h3BF_FFFF, 26'h3C0_0000, 26'h3C0_00FF, 26'h3C0_0100,
                      26'h3C0_01FF, 26'h3C0_0200, 26'h000_0000, 26'h3FF_FFFF};
        foreach (edge_addr[i])
        begin
            drive_request(edge_addr[i], 1'b1);
        end
        // half anywhere and half in a window around local and gap
        for (int i = 0; i < 200; i++)
        begin
            r = next_rand();
            if (r[7])
            begin
                drive_request(mem_addr_t'(next_rand()), r[1:0] != 2'b00);
            end
            else
            begin
                drive_request(LOCAL_BASE_ADDR[31:LINE_OFFSET_BITS] - 26'd256 +
                              mem_addr_t'(r[18:8]), r[1:0] != 2'b00);
            end
        end

        // response slot followed by two idle cycles so a parked entry drains
        for (int i = 0; i < 20; i++)
        begin
            r = next_rand();
            drive_response((i < 4) ? 2'(i) : r[5:4]);
            drive_response(2'b00);
            drive_response(2'b00);
        end

        // reads out of reset
        reg_cycle(1'b0, PC_REG_ADDR, '0, '0);
        reg_cycle(1'b0, STATUS_REG_ADDR, '0, '0);
        reg_cycle(1'b0, START_REG_ADDR, '0, '0);
        reg_cycle(1'b0, 32'hF000_800C, '0, '0);
        // strobed PC writes
        reg_cycle(1'b1, PC_REG_ADDR, 32'h1234_5678, 4'b0101);
        reg_cycle(1'b1, PC_REG_ADDR, 32'hAABB_CCDD, 4'b1000);
        r = next_rand();
        reg_cycle(1'b1, PC_REG_ADDR, next_rand(), reg_strobe_t'(r));
        reg_cycle(1'b1, PC_REG_ADDR, 32'h8000_0040, 4'b1111);
        reg_cycle(1'b0, PC_REG_ADDR, '0, '0);
        // start without strobe 0 and then without data bit 0
        reg_cycle(1'b1, START_REG_ADDR, 32'h0000_0001, 4'b1110);
        reg_cycle(1'b1, START_REG_ADDR, 32'hFFFF_FFFE, 4'b1111);
        reg_cycle(1'b0, STATUS_REG_ADDR, '0, '0);
        // proper start
        reg_cycle(1'b1, START_REG_ADDR, 32'h0000_0001, 4'b0001);
        reg_cycle(1'b0, STATUS_REG_ADDR, '0, '0);
        reg_cycle(1'b0, START_REG_ADDR, '0, '0);
        // busy pulse ends the run
        reg_cycle(1'b0, STATUS_REG_ADDR, '0, '0);
        set_busy(1'b1);
        set_busy(1'b1);
        set_busy(1'b1);
        set_busy(1'b0);
        set_busy(1'b0);
        set_busy(1'b0);

        // let the checker see the last driven cycle
        @(posedge clk);
        @(negedge clk);
        $display("errors: route %0d, response %0d, register %0d, reset %0d",
                 route_errs, rsp_errs, reg_errs, ctrl_errs);
        if (route_errs + rsp_errs + reg_errs + ctrl_errs == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // comparison on rising edges
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        logic [1:0] route;
        logic       exp_valid;
        mem_data_t  exp_data;
        mem_tag_t   exp_tag;
        if (!nRST)
        begin
            check_reset(gpu_reset, 1'b1, "gpu_reset in reset");
            pend_valid   = 1'b0;
            model_state  = RUN_HALT;
            model_pc     = PC_RESET_DEFAULT;
            model_busy_q = 1'b0;
        end
        else
        begin
            route = expect_route(req_valid, req_addr);
            check_route(local_req_valid, route[1], "local_req_valid");
            check_route(bus_req_valid, route[0], "bus_req_valid");
            check_route(req_ready, local_req_ready & bus_req_ready, "req_ready");

            // payload and response readies pass straight through
            check_route(fwd_rw, req_rw, "fwd_rw");
            check_fwd(fwd_byteen, fwd_addr, fwd_data, fwd_tag,
                      req_byteen, req_addr, req_data, req_tag);
            check_route(local_rsp_ready, rsp_ready, "local_rsp_ready");
            check_route(bus_rsp_ready, rsp_ready, "bus_rsp_ready");

            // local wins, bus alone passes, parked bus entry fills an empty cycle
            exp_valid = local_rsp_valid | bus_rsp_valid | pend_valid;
            exp_data  = local_rsp_valid ? local_rsp_data :
                        bus_rsp_valid   ? bus_rsp_data   : pend_data;
            exp_tag   = local_rsp_valid ? local_rsp_tag :
                        bus_rsp_valid   ? bus_rsp_tag   : pend_tag;
            check_rsp(rsp_valid, rsp_data, rsp_tag, exp_valid, exp_data, exp_tag);

            check_reg(reg_rdata, expect_rdata(reg_addr, model_state, model_pc), "reg_rdata");
            check_reg(gpu_pc_reset, model_pc, "gpu_pc_reset");
            check_reset(gpu_reset, model_state == RUN_HALT, "gpu_reset");

            // advance model across this edge
            pend_valid = local_rsp_valid & bus_rsp_valid;
            pend_data  = bus_rsp_data;
            pend_tag   = bus_rsp_tag;
            if (reg_wen && offset_match(reg_addr, PC_REG_ADDR))
            begin
                model_pc = expect_pc_merge(model_pc, reg_wdata, reg_strobe);
            end
            if (model_state == RUN_HALT)
            begin
                if (reg_wen && offset_match(reg_addr, START_REG_ADDR) &&
                    reg_strobe[0] && reg_wdata[0])
                begin
                    model_state = RUN_ACTIVE;
                end
            end
            else if (model_busy_q && !gpu_busy)
            begin
                model_state = RUN_HALT;
            end
            model_busy_q = gpu_busy;
        end
    end

    // watchdog
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+bench
logic/mem_bus_pkg.sv
logic/run_ctrl_pkg.sv
logic/mem_req_router.sv
logic/mem_rsp_merger.sv
logic/run_ctrl_regs.sv
logic/gpu_bridge_top.sv
bench/gpu_bridge_tb.sv
